// File: compile.f
rtl/dcache_pkg.sv
rtl/sync_fifo.sv
rtl/tag_decode.sv
rtl/tag_compare.sv
rtl/lookup_result.sv
rtl/dram_cache_lookup.sv
tests/tb_mem_model.sv
tests/tb_dram_cache_lookup.sv

// File: Makefile
# Verilator build and run for the DRAM cache lookup path
# any variable below can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_dram_cache_lookup
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= *** TEST FAILED ***
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi; \
	if [ $$status -ne 0 ] || ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/tb_dram_cache_lookup.sv
`timescale 1ns/1ns

module tb_dram_cache_lookup;

	localparam int NUM_ENTRIES    = 8;
	localparam int TIMEOUT_CYCLES = 60 * NUM_ENTRIES + 100;
	localparam int BEATS_PER_REQ  = dcache_pkg::LINE_BEATS + 1;

	// one row of the stimulus table with the resp_afull hold in cycles
	typedef struct packed {
		logic                              op;
		logic [dcache_pkg::TID_WIDTH-1:0]  tid;
		logic [dcache_pkg::ADDR_WIDTH-1:0] addr;
		logic                              meta_valid;
		logic                              tag_match;
		logic [7:0]                        hold;
	} stim_t;

	logic                              clk;
	logic                              rst_n;
	logic                              req_wren_i;
	dcache_pkg::tag_req_t              req_i;
	logic                              req_afull_o;
	logic                              rvalid_i;
	logic [dcache_pkg::BEAT_WIDTH-1:0] rdata_i;
	logic                              rlast_i;
	logic                              rready_o;
	logic                              resp_afull_i;
	logic                              resp_valid_o;
	dcache_pkg::rd_resp_t              resp_o;
	logic                              wack_valid_o;
	logic [dcache_pkg::TID_WIDTH-1:0]  wack_tid_o;
	logic                              fill_rden_i;
	logic                              fill_empty_o;
	dcache_pkg::fill_req_t             fill_data_o;
	logic [15:0]                       hit_count_o;
	logic [15:0]                       miss_count_o;

	stim_t                             stim [NUM_ENTRIES];
	logic [1:0]                        exp_kind [NUM_ENTRIES];
	logic [dcache_pkg::BEAT_WIDTH-1:0] meta_word [NUM_ENTRIES];
	dcache_pkg::line_t                 exp_line [NUM_ENTRIES];
	int                                exp_hits;
	int                                exp_misses;
	int                                next_res;
	int                                beats_taken;
	int                                cycle_count;
	logic                              fill_pending;
	logic                              fill_next;

	dram_cache_lookup #(
		.TAG_FIFO_DEPTH  (8),
		.FILL_FIFO_DEPTH (4)
	) UUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.req_wren_i   (req_wren_i),
		.req_i        (req_i),
		.req_afull_o  (req_afull_o),
		.rvalid_i     (rvalid_i),
		.rdata_i      (rdata_i),
		.rlast_i      (rlast_i),
		.rready_o     (rready_o),
		.resp_afull_i (resp_afull_i),
		.resp_valid_o (resp_valid_o),
		.resp_o       (resp_o),
		.wack_valid_o (wack_valid_o),
		.wack_tid_o   (wack_tid_o),
		.fill_rden_i  (fill_rden_i),
		.fill_empty_o (fill_empty_o),
		.fill_data_o  (fill_data_o),
		.hit_count_o  (hit_count_o),
		.miss_count_o (miss_count_o)
	);

	tb_mem_model u_mem (
		.clk      (clk),
		.rst_n    (rst_n),
		.rready_i (rready_o),
		.rvalid_o (rvalid_i),
		.rdata_o  (rdata_i),
		.rlast_o  (rlast_i)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#50;
			clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout: no verdict after %0d clock cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$fatal(1, "run aborted by the cycle limit");
		end
	end

	task automatic check_value(input string name, input logic [255:0] got,
			input logic [255:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// results must arrive in table order
	task automatic match_result(input string tid_name, input logic [1:0] kind,
			input logic [dcache_pkg::TID_WIDTH-1:0] tid,
			input logic [255:0] line, input logic [dcache_pkg::ADDR_WIDTH-1:0] addr);
		int k;
		k = next_res;
		if (k >= NUM_ENTRIES) begin
			$display("a result appeared after every request was already answered");
			$display("*** TEST FAILED ***");
			$fatal(1, "unexpected extra result");
		end else begin
			check_value("result kind", kind, exp_kind[k]);
			check_value(tid_name, tid, stim[k].tid);
			if (kind == dcache_pkg::RD_HIT) begin
				check_value("resp_o.line", line, exp_line[k]);
			end
			if (kind == dcache_pkg::RD_MISS || kind == dcache_pkg::WR_MISS) begin
				check_value("fill_data_o.line_addr", addr,
					{stim[k].addr[dcache_pkg::ADDR_WIDTH-1:dcache_pkg::OFFSET_WIDTH],
					{dcache_pkg::OFFSET_WIDTH{1'b0}}});
			end
			next_res = k + 1;
		end
	endtask

	task automatic build_table();
		logic [dcache_pkg::TAG_WIDTH-1:0] tag;
		logic                             hit;
		stim[0] = {dcache_pkg::OP_READ,  6'd5,  32'h1234_5678, 1'b1, 1'b1, 8'd0};
		stim[1] = {dcache_pkg::OP_READ,  6'd6,  32'hdead_beef, 1'b0, 1'b1, 8'd0};
		stim[2] = {dcache_pkg::OP_READ,  6'd7,  32'h0bad_f00d, 1'b1, 1'b0, 8'd0};
		stim[3] = {dcache_pkg::OP_WRITE, 6'd10, 32'h8000_0040, 1'b1, 1'b1, 8'd0};
		stim[4] = {dcache_pkg::OP_WRITE, 6'd11, 32'h4000_1fc0, 1'b1, 1'b0, 8'd0};
		stim[5] = {dcache_pkg::OP_READ,  6'd12, 32'hcafe_0100, 1'b1, 1'b1, 8'd8};
		stim[6] = {dcache_pkg::OP_WRITE, 6'd13, 32'h7f00_003f, 1'b0, 1'b1, 8'd0};
		stim[7] = {dcache_pkg::OP_READ,  6'd63, 32'hffff_ffc4, 1'b1, 1'b1, 8'd5};
		exp_hits   = 0;
		exp_misses = 0;
		for (int k = 0; k < NUM_ENTRIES; k++) begin
			tag = stim[k].addr[dcache_pkg::ADDR_WIDTH-1 -: dcache_pkg::TAG_WIDTH];
			meta_word[k] = {$urandom, $urandom};
			meta_word[k][dcache_pkg::META_VALID_BIT] = stim[k].meta_valid;
			// a mismatch uses the inverted request tag
			meta_word[k][dcache_pkg::TAG_WIDTH-1:0] = stim[k].tag_match ? tag : ~tag;
			for (int b = 0; b < dcache_pkg::LINE_BEATS; b++) begin
				exp_line[k][b] = {$urandom, $urandom};
			end
			hit = stim[k].meta_valid && stim[k].tag_match;
			if (hit) begin
				exp_hits = exp_hits + 1;
			end else begin
				exp_misses = exp_misses + 1;
			end
			if (stim[k].op == dcache_pkg::OP_READ) begin
				exp_kind[k] = hit ? dcache_pkg::RD_HIT : dcache_pkg::RD_MISS;
			end else begin
				exp_kind[k] = hit ? dcache_pkg::WR_HIT : dcache_pkg::WR_MISS;
			end
		end
	endtask

	task automatic push_requests();
		int   k;
		logic room;
		k = 0;
		while (k < NUM_ENTRIES) begin
			@(negedge clk);
			room = !req_afull_o;
			// the memory side gets its beats before the request enters the FIFO
			if (room) begin
				u_mem.load_request(meta_word[k], exp_line[k]);
			end
			@(posedge clk);
			#5;
			req_wren_i = room;
			if (room) begin
				req_i.op   = dcache_pkg::mem_op_e'(stim[k].op);
				req_i.tid  = stim[k].tid;
				req_i.addr = stim[k].addr;
				k = k + 1;
			end
		end
		@(posedge clk);
		#5;
		req_wren_i = 1'b0;
	endtask

	task automatic wait_for_beats(input int n);
		@(posedge clk);
		while (beats_taken < n) begin
			@(posedge clk);
		end
	endtask

	// raise resp_afull during the data beats, hold the finished lookup, then release
	task automatic apply_backpressure();
		for (int k = 0; k < NUM_ENTRIES; k++) begin
			if (stim[k].hold != 0) begin
				wait_for_beats(k * BEATS_PER_REQ + 1);
				#5;
				resp_afull_i = 1'b1;
				wait_for_beats((k + 1) * BEATS_PER_REQ);
				repeat (stim[k].hold) begin
					@(negedge clk);
					check_value("rready_o", rready_o, 1'b0);
					check_value("resp_valid_o", resp_valid_o, 1'b0);
					check_value("wack_valid_o", wack_valid_o, 1'b0);
				end
				@(posedge clk);
				check_value("results before release", next_res, k);
				#5;
				resp_afull_i = 1'b0;
			end
		end
	endtask

	// output monitor and refill engine
	initial begin
		fill_rden_i  = 1'b0;
		fill_pending = 1'b0;
		fill_next    = 1'b0;
		beats_taken  = 0;
		next_res     = 0;
		forever begin
			@(negedge clk);
			if (rvalid_i && rready_o) begin
				beats_taken = beats_taken + 1;
			end
			if (resp_valid_o) begin
				match_result("resp_o.tid", dcache_pkg::RD_HIT, resp_o.tid, resp_o.line, '0);
			end
			if (wack_valid_o) begin
				match_result("wack_tid_o", dcache_pkg::WR_HIT, wack_tid_o, '0, '0);
			end
			// fill data is registered and valid the cycle after the pop
			if (fill_pending) begin
				match_result("fill_data_o.tid",
					fill_data_o.is_write ? dcache_pkg::WR_MISS : dcache_pkg::RD_MISS,
					fill_data_o.tid, '0, fill_data_o.line_addr);
			end
			fill_pending = fill_rden_i;
			fill_next    = rst_n && !fill_empty_o && !fill_rden_i;
			@(posedge clk);
			#5;
			fill_rden_i = fill_next;
		end
	end

	initial begin
		rst_n        = 1'b0;
		req_wren_i   = 1'b0;
		req_i        = '0;
		resp_afull_i = 1'b0;
		cycle_count  = 0;
		void'($urandom(32'h1b7d438f));
		build_table();
		repeat (3) @(posedge clk);
		#5;
		rst_n = 1'b1;
		@(negedge clk);
		check_value("rready_o", rready_o, 1'b0);
		check_value("resp_valid_o", resp_valid_o, 1'b0);
		check_value("wack_valid_o", wack_valid_o, 1'b0);
		check_value("req_afull_o", req_afull_o, 1'b0);
		check_value("fill_empty_o", fill_empty_o, 1'b1);
		check_value("hit_count_o", hit_count_o, 0);
		check_value("miss_count_o", miss_count_o, 0);
		@(posedge clk);
		#5;
		fork
			push_requests();
			apply_backpressure();
		join
		while (next_res < NUM_ENTRIES) begin
			@(posedge clk);
		end
		@(negedge clk);
		check_value("hit_count_o", hit_count_o, exp_hits);
		check_value("miss_count_o", miss_count_o, exp_misses);
		check_value("fill_empty_o", fill_empty_o, 1'b1);
		check_value("rready_o", rready_o, 1'b0);
		check_value("model beats left", u_mem.pending_beats(), 0);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: tests/tb_mem_model.sv
`timescale 1ns/1ns

module tb_mem_model (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              rready_i,
	output logic                              rvalid_o,
	output logic [dcache_pkg::BEAT_WIDTH-1:0] rdata_o,
	output logic                              rlast_o
);

	// each queued beat is {last, data}
	logic [dcache_pkg::BEAT_WIDTH:0] beats [$];
	logic                            take;

	// metadata beat first, then the line from beat 0 upward
	task automatic load_request(input logic [dcache_pkg::BEAT_WIDTH-1:0] meta,
			input dcache_pkg::line_t line);
		beats.push_back({1'b0, meta});
		for (int b = 0; b < dcache_pkg::LINE_BEATS; b++) begin
			beats.push_back({(b == dcache_pkg::LINE_BEATS - 1), line[b]});
		end
	endtask

	function automatic int pending_beats();
		return beats.size();
	endfunction

	initial begin
		rvalid_o = 1'b0;
		rdata_o  = '0;
		rlast_o  = 1'b0;
		take     = 1'b0;
		forever begin
			@(negedge clk);
			// a beat seen with rready here is taken at the next rising edge
			take = rst_n && rvalid_o && rready_i;
			@(posedge clk);
			#5;
			if (take) begin
				void'(beats.pop_front());
			end
			rvalid_o = (beats.size() != 0);
			rdata_o  = (beats.size() != 0) ? beats[0][dcache_pkg::BEAT_WIDTH-1:0] : '0;
			rlast_o  = (beats.size() != 0) ? beats[0][dcache_pkg::BEAT_WIDTH] : 1'b0;
		end
	end

endmodule

// File: rtl/dram_cache_lookup.sv
`timescale 1ns/1ns

module dram_cache_lookup #(
	parameter int TAG_FIFO_DEPTH  = 8,
	parameter int FILL_FIFO_DEPTH = 4
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               req_wren_i,
	input  dcache_pkg::tag_req_t               req_i,
	output logic                               req_afull_o,
	input  logic                               rvalid_i,
	input  logic [dcache_pkg::BEAT_WIDTH-1:0]  rdata_i,
	input  logic                               rlast_i,
	output logic                               rready_o,
	input  logic                               resp_afull_i,
	output logic                               resp_valid_o,
	output dcache_pkg::rd_resp_t               resp_o,
	output logic                               wack_valid_o,
	output logic [dcache_pkg::TID_WIDTH-1:0]   wack_tid_o,
	input  logic                               fill_rden_i,
	output logic                               fill_empty_o,
	output dcache_pkg::fill_req_t              fill_data_o,
	output logic [15:0]                        hit_count_o,
	output logic [15:0]                        miss_count_o
);

	dcache_pkg::tag_req_t    tag_rdata;
	logic                    tag_rden;
	logic                    tag_empty;
	logic                    tag_aempty;
	logic                    dec_valid;
	dcache_pkg::lookup_req_t dec_req;
	logic                    cmp_idle;
	logic                    res_wren;
	dcache_pkg::cmp_result_t cmp_result;
	logic                    res_stall;
	logic                    fill_wren;
	dcache_pkg::fill_req_t   fill_wdata;
	logic                    fill_afull;

	// two slots of margin so a pusher one cycle late on afull still fits
	sync_fifo #(
		.DEPTH        (TAG_FIFO_DEPTH),
		.AFULL_MARGIN (2),
		.T            (dcache_pkg::tag_req_t)
	) u_tag_fifo (
		.clk      (clk),
		.rst_n    (rst_n),
		.wren_i   (req_wren_i),
		.wdata_i  (req_i),
		.rden_i   (tag_rden),
		.rdata_o  (tag_rdata),
		.empty_o  (tag_empty),
		.aempty_o (tag_aempty),
		.afull_o  (req_afull_o)
	);

	tag_decode u_decode (
		.clk           (clk),
		.rst_n         (rst_n),
		.fifo_aempty_i (tag_aempty),
		.fifo_empty_i  (tag_empty),
		.fifo_data_i   (tag_rdata),
		.cmp_idle_i    (cmp_idle),
		.fifo_rden_o   (tag_rden),
		.dec_valid_o   (dec_valid),
		.dec_req_o     (dec_req)
	);

	tag_compare u_compare (
		.clk         (clk),
		.rst_n       (rst_n),
		.dec_valid_i (dec_valid),
		.dec_req_i   (dec_req),
		.rvalid_i    (rvalid_i),
		.rdata_i     (rdata_i),
		.rlast_i     (rlast_i),
		.res_stall_i (res_stall),
		.rready_o    (rready_o),
		.cmp_idle_o  (cmp_idle),
		.res_wren_o  (res_wren),
		.res_o       (cmp_result)
	);

	lookup_result u_result (
		.clk          (clk),
		.rst_n        (rst_n),
		.res_wren_i   (res_wren),
		.res_i        (cmp_result),
		.resp_afull_i (resp_afull_i),
		.fill_afull_i (fill_afull),
		.res_stall_o  (res_stall),
		.resp_valid_o (resp_valid_o),
		.resp_o       (resp_o),
		.fill_wren_o  (fill_wren),
		.fill_o       (fill_wdata),
		.wack_valid_o (wack_valid_o),
		.wack_tid_o   (wack_tid_o),
		.hit_count_o  (hit_count_o),
		.miss_count_o (miss_count_o)
	);

	// only one lookup is in flight, so one slot of margin is enough
	sync_fifo #(
		.DEPTH        (FILL_FIFO_DEPTH),
		.AFULL_MARGIN (1),
		.T            (dcache_pkg::fill_req_t)
	) u_fill_fifo (
		.clk      (clk),
		.rst_n    (rst_n),
		.wren_i   (fill_wren),
		.wdata_i  (fill_wdata),
		.rden_i   (fill_rden_i),
		.rdata_o  (fill_data_o),
		.empty_o  (fill_empty_o),
		.aempty_o (),
		.afull_o  (fill_afull)
	);

endmodule

// File: rtl/lookup_result.sv
`timescale 1ns/1ns

module lookup_result (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               res_wren_i,
	input  dcache_pkg::cmp_result_t            res_i,
	input  logic                               resp_afull_i,
	input  logic                               fill_afull_i,
	output logic                               res_stall_o,
	output logic                               resp_valid_o,
	output dcache_pkg::rd_resp_t               resp_o,
	output logic                               fill_wren_o,
	output dcache_pkg::fill_req_t              fill_o,
	output logic                               wack_valid_o,
	output logic [dcache_pkg::TID_WIDTH-1:0]   wack_tid_o,
	output logic [15:0]                        hit_count_o,
	output logic [15:0]                        miss_count_o
);

	logic                             resp_valid_q;
	logic                             fill_wren_q;
	logic                             wack_valid_q;
	dcache_pkg::rd_resp_t             resp_q;
	dcache_pkg::fill_req_t            fill_q;
	logic [dcache_pkg::TID_WIDTH-1:0] wack_tid_q;
	logic [15:0]                      hit_cnt_q;
	logic [15:0]                      miss_cnt_q;

	assign res_stall_o = resp_afull_i || fill_afull_i;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			resp_valid_q <= 1'b0;
			fill_wren_q  <= 1'b0;
			wack_valid_q <= 1'b0;
			hit_cnt_q    <= '0;
			miss_cnt_q   <= '0;
		end else begin
			resp_valid_q <= res_wren_i && (res_i.kind == dcache_pkg::RD_HIT);
			wack_valid_q <= res_wren_i && (res_i.kind == dcache_pkg::WR_HIT);
			fill_wren_q  <= res_wren_i && (res_i.kind == dcache_pkg::RD_MISS
				|| res_i.kind == dcache_pkg::WR_MISS);
			if (res_wren_i) begin
				if (res_i.kind == dcache_pkg::RD_HIT || res_i.kind == dcache_pkg::WR_HIT) begin
					hit_cnt_q <= hit_cnt_q + 16'd1;
				end else begin
					miss_cnt_q <= miss_cnt_q + 16'd1;
				end
			end
		end
	end

	// payloads follow the strobe and the line address has its offset cleared
	always_ff @(posedge clk) begin
		if (res_wren_i) begin
			resp_q.tid         <= res_i.tid;
			resp_q.line        <= res_i.line;
			wack_tid_q         <= res_i.tid;
			fill_q.is_write    <= (res_i.kind == dcache_pkg::WR_MISS);
			fill_q.tid         <= res_i.tid;
			fill_q.line_addr   <= {res_i.tag, res_i.index, {dcache_pkg::OFFSET_WIDTH{1'b0}}};
		end
	end

	assign resp_valid_o = resp_valid_q;
	assign resp_o       = resp_q;
	assign fill_wren_o  = fill_wren_q;
	assign fill_o       = fill_q;
	assign wack_valid_o = wack_valid_q;
	assign wack_tid_o   = wack_tid_q;
	assign hit_count_o  = hit_cnt_q;
	assign miss_count_o = miss_cnt_q;

	// the compare stage hands over a result only after a cycle without stall
	a_wren_after_room: assert property (@(posedge clk) disable iff (!rst_n)
		res_wren_i |-> $past(!res_stall_o));

endmodule

// File: rtl/tag_compare.sv
`timescale 1ns/1ns

module tag_compare (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                dec_valid_i,
	input  dcache_pkg::lookup_req_t             dec_req_i,
	input  logic                                rvalid_i,
	input  logic [dcache_pkg::BEAT_WIDTH-1:0]   rdata_i,
	input  logic                                rlast_i,
	input  logic                                res_stall_i,
	output logic                                rready_o,
	output logic                                cmp_idle_o,
	output logic                                res_wren_o,
	output dcache_pkg::cmp_result_t             res_o
);

	localparam int CNT_W = $clog2(dcache_pkg::LINE_BEATS);
	localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(dcache_pkg::LINE_BEATS - 1);

	dcache_pkg::cmp_state_e  state_q;
	dcache_pkg::cmp_state_e  state_d;
	dcache_pkg::lookup_req_t req_q;
	dcache_pkg::line_t       line_q;
	logic                    hit_q;
	logic [CNT_W-1:0]        beat_cnt_q;
	logic                    res_wren_q;
	logic                    beat_ok;
	logic                    meta_hit;

	assign beat_ok = rvalid_i && rready_o;

	// metadata beat: valid flag on top, tag in the low bits
	assign meta_hit = rdata_i[dcache_pkg::META_VALID_BIT]
		&& (rdata_i[dcache_pkg::TAG_WIDTH-1:0] == req_q.tag);

	always_comb begin
		state_d = state_q;
		case (state_q)
			dcache_pkg::S_IDLE: begin
				if (dec_valid_i) begin
					state_d = dcache_pkg::S_META;
				end
			end
			dcache_pkg::S_META: begin
				if (beat_ok) begin
					state_d = dcache_pkg::S_DATA;
				end
			end
			dcache_pkg::S_DATA: begin
				if (beat_ok && beat_cnt_q == LAST_BEAT) begin
					state_d = dcache_pkg::S_DONE;
				end
			end
			dcache_pkg::S_DONE: begin
				// hold the finished lookup until the result side has room
				if (!res_stall_i) begin
					state_d = dcache_pkg::S_IDLE;
				end
			end
			default: begin
				state_d = dcache_pkg::S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q    <= dcache_pkg::S_IDLE;
			hit_q      <= 1'b0;
			beat_cnt_q <= '0;
			res_wren_q <= 1'b0;
		end else begin
			state_q    <= state_d;
			res_wren_q <= (state_q == dcache_pkg::S_DONE) && !res_stall_i;
			if (state_q == dcache_pkg::S_META && beat_ok) begin
				hit_q      <= meta_hit;
				beat_cnt_q <= '0;
			end else if (state_q == dcache_pkg::S_DATA && beat_ok) begin
				beat_cnt_q <= beat_cnt_q + 1'b1;
			end
		end
	end

	// misses and writes still drain the data beats, only a read hit keeps them
	always_ff @(posedge clk) begin
		if (state_q == dcache_pkg::S_IDLE && dec_valid_i) begin
			req_q <= dec_req_i;
		end
		if (state_q == dcache_pkg::S_DATA && beat_ok && hit_q
				&& req_q.op == dcache_pkg::OP_READ) begin
			line_q[beat_cnt_q] <= rdata_i;
		end
	end

	always_comb begin
		res_o.tid   = req_q.tid;
		res_o.tag   = req_q.tag;
		res_o.index = req_q.index;
		res_o.line  = line_q;
		if (req_q.op == dcache_pkg::OP_READ) begin
			res_o.kind = hit_q ? dcache_pkg::RD_HIT : dcache_pkg::RD_MISS;
		end else begin
			res_o.kind = hit_q ? dcache_pkg::WR_HIT : dcache_pkg::WR_MISS;
		end
	end

	assign rready_o   = (state_q == dcache_pkg::S_META) || (state_q == dcache_pkg::S_DATA);
	assign cmp_idle_o = (state_q == dcache_pkg::S_IDLE);
	assign res_wren_o = res_wren_q;

	// memory side must mark the last data beat of the line, and only that one
	a_rlast_final: assert property (@(posedge clk) disable iff (!rst_n)
		(beat_ok && rlast_i) |-> (state_q == dcache_pkg::S_DATA && beat_cnt_q == LAST_BEAT));

endmodule

// File: rtl/tag_decode.sv
`timescale 1ns/1ns

module tag_decode (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    fifo_aempty_i,
	input  logic                    fifo_empty_i,
	input  dcache_pkg::tag_req_t    fifo_data_i,
	input  logic                    cmp_idle_i,
	output logic                    fifo_rden_o,
	output logic                    dec_valid_o,
	output dcache_pkg::lookup_req_t dec_req_o
);

	logic                    rden_q;
	logic                    latch_q;
	logic                    dec_valid_q;
	logic                    busy;
	logic                    pop;
	dcache_pkg::lookup_req_t dec_req_q;

	// one request in flight from pop until the compare stage takes it
	assign busy = rden_q || latch_q || dec_valid_q;

	// a lone entry below the almost-empty level is still popped when idle
	assign pop = cmp_idle_i && !busy && (!fifo_aempty_i || !fifo_empty_i);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rden_q      <= 1'b0;
			latch_q     <= 1'b0;
			dec_valid_q <= 1'b0;
		end else begin
			rden_q      <= pop;
			latch_q     <= rden_q;
			dec_valid_q <= latch_q;
		end
	end

	// fifo read data is valid the cycle after rden
	always_ff @(posedge clk) begin
		if (latch_q) begin
			dec_req_q.op    <= fifo_data_i.op;
			dec_req_q.tid   <= fifo_data_i.tid;
			dec_req_q.tag   <= fifo_data_i.addr[dcache_pkg::ADDR_WIDTH-1 -: dcache_pkg::TAG_WIDTH];
			dec_req_q.index <= fifo_data_i.addr[dcache_pkg::OFFSET_WIDTH +: dcache_pkg::INDEX_WIDTH];
		end
	end

	assign fifo_rden_o = rden_q;
	assign dec_valid_o = dec_valid_q;
	assign dec_req_o   = dec_req_q;

endmodule

// File: rtl/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
	parameter int  DEPTH        = 8,
	parameter int  AFULL_MARGIN = 1,
	parameter type T            = logic
) (
	input  logic clk,
	input  logic rst_n,
	input  logic wren_i,
	input  T     wdata_i,
	input  logic rden_i,
	output T     rdata_o,
	output logic empty_o,
	output logic aempty_o,
	output logic afull_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

	T                 mem [DEPTH];
	T                 rdata_q;
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (wren_i) begin
				wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
			end
			if (rden_i) begin
				rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
			end
			case ({wren_i, rden_i})
				2'b10: begin
					count_q <= count_q + 1'b1;
				end
				2'b01: begin
					count_q <= count_q - 1'b1;
				end
				default: begin
					count_q <= count_q;
				end
			endcase
		end
	end

	// storage and read data
	always_ff @(posedge clk) begin
		if (wren_i) begin
			mem[wr_ptr_q] <= wdata_i;
		end
		if (rden_i) begin
			rdata_q <= mem[rd_ptr_q];
		end
	end

	assign rdata_o  = rdata_q;
	assign empty_o  = (count_q == '0);
	assign aempty_o = (count_q <= CNT_W'(1));
	assign afull_o  = (count_q >= CNT_W'(DEPTH - AFULL_MARGIN));

	// the producer is expected to honour afull
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		!(wren_i && count_q == CNT_W'(DEPTH)));

	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		!(rden_i && count_q == '0));

endmodule

// File: rtl/dcache_pkg.sv
package dcache_pkg;

	// address split: tag | index | offset
	localparam int ADDR_WIDTH     = 32;
	localparam int TID_WIDTH      = 6;
	localparam int INDEX_WIDTH    = 8;
	localparam int OFFSET_WIDTH   = 6;
	localparam int TAG_WIDTH      = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

	// R channel beat and line shape
	localparam int BEAT_WIDTH     = 64;
	localparam int LINE_BEATS     = 4;
	localparam int META_VALID_BIT = 63;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} mem_op_e;

	typedef enum logic [1:0] {
		RD_HIT  = 2'd0,
		RD_MISS = 2'd1,
		WR_HIT  = 2'd2,
		WR_MISS = 2'd3
	} lookup_kind_e;

	typedef enum logic [1:0] {
		S_IDLE = 2'd0,
		S_META = 2'd1,
		S_DATA = 2'd2,
		S_DONE = 2'd3
	} cmp_state_e;

	// beat 0 sits in the low slot
	typedef logic [LINE_BEATS-1:0][BEAT_WIDTH-1:0] line_t;

	typedef struct packed {
		mem_op_e                 op;
		logic [TID_WIDTH-1:0]    tid;
		logic [ADDR_WIDTH-1:0]   addr;
	} tag_req_t;

	typedef struct packed {
		mem_op_e                 op;
		logic [TID_WIDTH-1:0]    tid;
		logic [TAG_WIDTH-1:0]    tag;
		logic [INDEX_WIDTH-1:0]  index;
	} lookup_req_t;

	typedef struct packed {
		lookup_kind_e            kind;
		logic [TID_WIDTH-1:0]    tid;
		logic [TAG_WIDTH-1:0]    tag;
		logic [INDEX_WIDTH-1:0]  index;
		line_t                   line;
	} cmp_result_t;

	typedef struct packed {
		logic [TID_WIDTH-1:0]    tid;
		line_t                   line;
	} rd_resp_t;

	typedef struct packed {
		logic                    is_write;
		logic [TID_WIDTH-1:0]    tid;
		logic [ADDR_WIDTH-1:0]   line_addr;
	} fill_req_t;

endpackage
